// File: hw/vcache_pkg.sv
// ==========================================================================
// vcache shared definitions
// tile controller states, statistics counter width and the word offsets
// of the configuration bus
// ==========================================================================

package vcache_pkg;

  // tile controller state
  typedef enum logic [2:0] {
    INIT,
    IDLE,
    LOOKUP,
    FILL,
    WRITE,
    BYPASS
  } tile_state_e;

  // hit and miss counters
  localparam int cnt_width_c = 16;

  // configuration bus word address width
  localparam int cfg_adr_width_c = 6;

  // bypass mask, one bit per tile
  localparam logic [5:0] reg_bypass_c = 6'd0;

  // hits of tile k at base plus k
  localparam logic [5:0] reg_hits_base_c = 6'd16;

  // misses of tile k at base plus k
  localparam logic [5:0] reg_misses_base_c = 6'd32;

endpackage

// File: hw/vcache_store.sv
// ==========================================================================
// vcache storage array
// single port, synchronous read, write-first; payload type set by the
// instantiating tile so one array serves both tags and data words
// ==========================================================================

`timescale 1ns/10ps

module vcache_store
  #(parameter type payload_t = logic
    , parameter int depth_p = 8
    , localparam int addr_width_lp = $clog2(depth_p)
  )
  (
    input clk_i
    , input we_i
    , input [addr_width_lp-1:0] addr_i
    , input payload_t wdata_i
    , output payload_t rdata_o
  );

  payload_t mem_r [depth_p];

  // new data shows on the read port in the write cycle
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_r[addr_i] <= wdata_i;
      rdata_o <= wdata_i;
    end
    else begin
      rdata_o <= mem_r[addr_i];
    end
  end

endmodule

// File: hw/vcache_tile.sv
// ==========================================================================
// vcache tile
// direct-mapped, write-through, no-write-allocate cache with one word per
// block; Wishbone classic slave to the north, master to the south; one
// stage of the reset chain
// ==========================================================================

`timescale 1ns/10ps

module vcache_tile
  #(parameter int sets_p = 8
    , parameter int addr_width_p = 12
    , parameter int data_width_p = 32
    , localparam int index_width_lp = $clog2(sets_p)
    , localparam int tag_width_lp = addr_width_p - index_width_lp
  )
  (
    input clk_i
    , input reset_i
    , output logic reset_o
    , input bypass_i

    // north, from the cores
    , input n_cyc_i
    , input n_stb_i
    , input n_we_i
    , input [addr_width_p-1:0] n_adr_i
    , input [data_width_p-1:0] n_dat_i
    , output logic [data_width_p-1:0] n_dat_o
    , output logic n_ack_o

    // south, to memory
    , output logic s_cyc_o
    , output logic s_stb_o
    , output logic s_we_o
    , output logic [addr_width_p-1:0] s_adr_o
    , output logic [data_width_p-1:0] s_dat_o
    , input [data_width_p-1:0] s_dat_i
    , input s_ack_i

    , output logic hit_o
    , output logic miss_o
  );

  typedef struct packed {
    logic valid;
    logic [tag_width_lp-1:0] tag;
  } tag_entry_s;

  vcache_pkg::tile_state_e state_r;
  logic [index_width_lp-1:0] init_cnt_r;

  logic req_we_r;
  logic [addr_width_p-1:0] req_adr_r;
  logic [data_width_p-1:0] req_dat_r;
  logic [data_width_p-1:0] n_dat_r;

  logic s_req_r;
  logic n_ack_r;
  logic hit_r;
  logic miss_r;

  logic accept;
  logic hit;
  logic [index_width_lp-1:0] store_idx;
  logic tag_we;
  tag_entry_s tag_wdata;
  tag_entry_s tag_rdata;
  logic data_we;
  logic [data_width_p-1:0] data_wdata;
  logic [data_width_p-1:0] data_rdata;

  // one registered stage of the reset chain
  always_ff @(posedge clk_i) begin
    reset_o <= reset_i;
  end

  // no new request while the previous ack is still up
  assign accept = (state_r == vcache_pkg::IDLE) && n_cyc_i && n_stb_i && !n_ack_r;

  always_comb begin
    if (accept) begin
      store_idx = n_adr_i[index_width_lp-1:0];
    end
    else if (state_r == vcache_pkg::INIT) begin
      store_idx = init_cnt_r;
    end
    else begin
      store_idx = req_adr_r[index_width_lp-1:0];
    end
  end

  assign hit = tag_rdata.valid
               && (tag_rdata.tag == req_adr_r[addr_width_p-1:index_width_lp]);

  // sweep clears valid, fill installs the line
  assign tag_we = (state_r == vcache_pkg::INIT) || ((state_r == vcache_pkg::FILL) && s_ack_i);
  assign tag_wdata = (state_r == vcache_pkg::INIT)
                     ? '0
                     : {1'b1, req_adr_r[addr_width_p-1:index_width_lp]};

  // write hit updates the word as the write goes south
  assign data_we = ((state_r == vcache_pkg::LOOKUP) && req_we_r && hit)
                   || ((state_r == vcache_pkg::FILL) && s_ack_i);
  assign data_wdata = (state_r == vcache_pkg::FILL) ? s_dat_i : req_dat_r;

  vcache_store #(
    .payload_t(tag_entry_s)
    ,.depth_p(sets_p)
  ) i_tag_store (
    .clk_i(clk_i)
    ,.we_i(tag_we)
    ,.addr_i(store_idx)
    ,.wdata_i(tag_wdata)
    ,.rdata_o(tag_rdata)
  );

  vcache_store #(
    .payload_t(logic [data_width_p-1:0])
    ,.depth_p(sets_p)
  ) i_data_store (
    .clk_i(clk_i)
    ,.we_i(data_we)
    ,.addr_i(store_idx)
    ,.wdata_i(data_wdata)
    ,.rdata_o(data_rdata)
  );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= vcache_pkg::INIT;
      init_cnt_r <= '0;
      s_req_r <= 1'b0;
      n_ack_r <= 1'b0;
      hit_r <= 1'b0;
      miss_r <= 1'b0;
    end
    else begin
      n_ack_r <= 1'b0;
      hit_r <= 1'b0;
      miss_r <= 1'b0;
      case (state_r)
        vcache_pkg::INIT: begin
          init_cnt_r <= init_cnt_r + 1'b1;
          if (init_cnt_r == index_width_lp'(sets_p - 1)) begin
            state_r <= vcache_pkg::IDLE;
          end
        end
        vcache_pkg::IDLE: begin
          if (accept) begin
            state_r <= vcache_pkg::LOOKUP;
          end
        end
        vcache_pkg::LOOKUP: begin
          if (req_we_r) begin
            state_r <= vcache_pkg::WRITE;
            s_req_r <= 1'b1;
          end
          else if (bypass_i) begin
            state_r <= vcache_pkg::BYPASS;
            s_req_r <= 1'b1;
          end
          else if (hit) begin
            state_r <= vcache_pkg::IDLE;
            n_ack_r <= 1'b1;
            hit_r <= 1'b1;
          end
          else begin
            state_r <= vcache_pkg::FILL;
            s_req_r <= 1'b1;
          end
        end
        vcache_pkg::FILL, vcache_pkg::WRITE, vcache_pkg::BYPASS: begin
          // late south ack just holds everything
          if (s_ack_i) begin
            state_r <= vcache_pkg::IDLE;
            s_req_r <= 1'b0;
            n_ack_r <= 1'b1;
            miss_r <= (state_r == vcache_pkg::FILL);
          end
        end
        default: state_r <= vcache_pkg::INIT;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_we_r <= n_we_i;
      req_adr_r <= n_adr_i;
      req_dat_r <= n_dat_i;
    end
    if (state_r == vcache_pkg::LOOKUP) begin
      n_dat_r <= data_rdata;
    end
    else if (s_req_r && s_ack_i) begin
      n_dat_r <= s_dat_i;
    end
  end

  assign n_dat_o = n_dat_r;
  assign n_ack_o = n_ack_r;
  assign s_cyc_o = s_req_r;
  assign s_stb_o = s_req_r;
  assign s_we_o = req_we_r;
  assign s_adr_o = req_adr_r;
  assign s_dat_o = req_dat_r;
  assign hit_o = hit_r;
  assign miss_o = miss_r;

endmodule

// File: hw/vcache_cfg_regs.sv
// ==========================================================================
// vcache configuration and statistics registers
// Wishbone classic slave with a registered ack; holds the per-tile read
// bypass mask and saturating hit and miss counters, cleared by a write
// ==========================================================================

`timescale 1ns/10ps

module vcache_cfg_regs
  #(parameter int num_tiles_p = 4
    , parameter int data_width_p = 32
    , localparam int adr_width_lp = vcache_pkg::cfg_adr_width_c
    , localparam int cnt_width_lp = vcache_pkg::cnt_width_c
  )
  (
    input clk_i
    , input reset_i

    , input wb_cyc_i
    , input wb_stb_i
    , input wb_we_i
    , input [adr_width_lp-1:0] wb_adr_i
    , input [data_width_p-1:0] wb_dat_i
    , output logic [data_width_p-1:0] wb_dat_o
    , output logic wb_ack_o

    , input [num_tiles_p-1:0] hit_i
    , input [num_tiles_p-1:0] miss_i
    , output logic [num_tiles_p-1:0] bypass_o
  );

  logic stb_seen;
  logic wr_en;
  logic ack_r;
  logic [data_width_p-1:0] dat_r;
  logic [data_width_p-1:0] rd_data;
  logic [num_tiles_p-1:0] bypass_r;

  // index 0 is hits, index 1 is misses
  logic [1:0][num_tiles_p-1:0] ev;
  logic [1:0][num_tiles_p-1:0] sel;
  logic [1:0][num_tiles_p-1:0][cnt_width_lp-1:0] cnt;

  assign stb_seen = wb_cyc_i && wb_stb_i && !ack_r;
  assign wr_en = stb_seen && wb_we_i;
  assign ev = {miss_i, hit_i};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_r <= 1'b0;
      bypass_r <= '0;
    end
    else begin
      ack_r <= stb_seen;
      if (wr_en && (wb_adr_i == vcache_pkg::reg_bypass_c)) begin
        bypass_r <= wb_dat_i[num_tiles_p-1:0];
      end
    end
  end

  for (genvar k = 0; k < num_tiles_p; k++) begin : g_tile
    for (genvar s = 0; s < 2; s++) begin : g_kind
      localparam int offset_lp = (s == 0 ? vcache_pkg::reg_hits_base_c
                                         : vcache_pkg::reg_misses_base_c) + k;
      logic [cnt_width_lp-1:0] count_r;

      assign sel[s][k] = (wb_adr_i == adr_width_lp'(offset_lp));

      // saturate at all ones, any write clears
      always_ff @(posedge clk_i) begin
        if (reset_i) begin
          count_r <= '0;
        end
        else if (wr_en && sel[s][k]) begin
          count_r <= '0;
        end
        else if (ev[s][k] && (count_r != '1)) begin
          count_r <= count_r + 1'b1;
        end
      end

      assign cnt[s][k] = count_r;
    end
  end

  // unmapped offsets read as zero
  always_comb begin
    rd_data = '0;
    if (wb_adr_i == vcache_pkg::reg_bypass_c) begin
      rd_data = data_width_p'(bypass_r);
    end
    for (int s = 0; s < 2; s++) begin
      for (int k = 0; k < num_tiles_p; k++) begin
        if (sel[s][k]) begin
          rd_data = data_width_p'(cnt[s][k]);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (stb_seen) begin
      dat_r <= rd_data;
    end
  end

  assign wb_dat_o = dat_r;
  assign wb_ack_o = ack_r;
  assign bypass_o = bypass_r;

endmodule

// File: hw/vcache_tile_array.sv
// ==========================================================================
// vcache tile array
// a row of cache tiles, one per core column, with reset passed down the
// row one register per tile; configuration block sits beside the row
// ==========================================================================

`timescale 1ns/10ps

module vcache_tile_array
  #(parameter int num_tiles_p = 4
    , parameter int sets_p = 8
    , parameter int addr_width_p = 12
    , parameter int data_width_p = 32
  )
  (
    input clk_i
    , input reset_i

    // configuration port
    , input cfg_cyc_i
    , input cfg_stb_i
    , input cfg_we_i
    , input [vcache_pkg::cfg_adr_width_c-1:0] cfg_adr_i
    , input [data_width_p-1:0] cfg_dat_i
    , output logic [data_width_p-1:0] cfg_dat_o
    , output logic cfg_ack_o

    // north, one port per tile
    , input [num_tiles_p-1:0] n_cyc_i
    , input [num_tiles_p-1:0] n_stb_i
    , input [num_tiles_p-1:0] n_we_i
    , input [num_tiles_p-1:0][addr_width_p-1:0] n_adr_i
    , input [num_tiles_p-1:0][data_width_p-1:0] n_dat_i
    , output logic [num_tiles_p-1:0][data_width_p-1:0] n_dat_o
    , output logic [num_tiles_p-1:0] n_ack_o

    // south, one port per tile
    , output logic [num_tiles_p-1:0] s_cyc_o
    , output logic [num_tiles_p-1:0] s_stb_o
    , output logic [num_tiles_p-1:0] s_we_o
    , output logic [num_tiles_p-1:0][addr_width_p-1:0] s_adr_o
    , output logic [num_tiles_p-1:0][data_width_p-1:0] s_dat_o
    , input [num_tiles_p-1:0][data_width_p-1:0] s_dat_i
    , input [num_tiles_p-1:0] s_ack_i
  );

  logic [num_tiles_p-1:0] reset_li;
  logic [num_tiles_p-1:0] reset_lo;
  logic [num_tiles_p-1:0] hit_lo;
  logic [num_tiles_p-1:0] miss_lo;
  logic [num_tiles_p-1:0] bypass_lo;

  vcache_cfg_regs #(
    .num_tiles_p(num_tiles_p)
    ,.data_width_p(data_width_p)
  ) i_cfg_regs (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.wb_cyc_i(cfg_cyc_i)
    ,.wb_stb_i(cfg_stb_i)
    ,.wb_we_i(cfg_we_i)
    ,.wb_adr_i(cfg_adr_i)
    ,.wb_dat_i(cfg_dat_i)
    ,.wb_dat_o(cfg_dat_o)
    ,.wb_ack_o(cfg_ack_o)
    ,.hit_i(hit_lo)
    ,.miss_i(miss_lo)
    ,.bypass_o(bypass_lo)
  );

  for (genvar x = 0; x < num_tiles_p; x++) begin : g_tile
    // tile x leaves reset x cycles after tile 0
    if (x == 0) begin : g_head
      assign reset_li[x] = reset_i;
    end
    else begin : g_link
      assign reset_li[x] = reset_lo[x-1];
    end

    vcache_tile #(
      .sets_p(sets_p)
      ,.addr_width_p(addr_width_p)
      ,.data_width_p(data_width_p)
    ) i_tile (
      .clk_i(clk_i)
      ,.reset_i(reset_li[x])
      ,.reset_o(reset_lo[x])
      ,.bypass_i(bypass_lo[x])
      ,.n_cyc_i(n_cyc_i[x])
      ,.n_stb_i(n_stb_i[x])
      ,.n_we_i(n_we_i[x])
      ,.n_adr_i(n_adr_i[x])
      ,.n_dat_i(n_dat_i[x])
      ,.n_dat_o(n_dat_o[x])
      ,.n_ack_o(n_ack_o[x])
      ,.s_cyc_o(s_cyc_o[x])
      ,.s_stb_o(s_stb_o[x])
      ,.s_we_o(s_we_o[x])
      ,.s_adr_o(s_adr_o[x])
      ,.s_dat_o(s_dat_o[x])
      ,.s_dat_i(s_dat_i[x])
      ,.s_ack_i(s_ack_i[x])
      ,.hit_o(hit_lo[x])
      ,.miss_o(miss_lo[x])
    );
  end

endmodule

// File: verification/vcache_assertions.sv
// ==========================================================================
// vcache tile protocol assertions
// north and south Wishbone handshake rules of one tile, bound to every tile
// ==========================================================================

`timescale 1ns/10ps

module vcache_assertions
  #(parameter int addr_width_p = 12
    , parameter int data_width_p = 32
  )
  (
    input clk_i
    , input reset_i
    , input vcache_pkg::tile_state_e state_i
    , input n_cyc_i
    , input n_stb_i
    , input n_ack_i
    , input s_stb_i
    , input s_we_i
    , input [addr_width_p-1:0] s_adr_i
    , input [data_width_p-1:0] s_wdat_i
    , input s_ack_i
  );

  north_ack_in_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    n_ack_i |-> (n_cyc_i && n_stb_i))
    else $error("north ack without cyc and stb");

  // request fields held while memory is slow
  south_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (s_stb_i && !s_ack_i) |=> (s_stb_i && $stable(s_we_i) && $stable(s_adr_i)
                               && $stable(s_wdat_i)))
    else $error("south request changed before ack");

  north_ack_single: assert property (@(posedge clk_i) disable iff (reset_i)
    n_ack_i |=> !n_ack_i)
    else $error("north ack longer than one cycle");

  south_ack_single: assert property (@(posedge clk_i) disable iff (reset_i)
    s_ack_i |=> !s_ack_i)
    else $error("south ack longer than one cycle");

  no_ack_in_init: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_i == vcache_pkg::INIT) |-> !n_ack_i)
    else $error("north ack during init sweep");

endmodule

// File: verification/vcache_checker.sv
// ==========================================================================
// vcache response checker
// watches north and configuration acks, compares read data with the
// expected value of the request in flight and counts finished tests
// ==========================================================================

`timescale 1ns/10ps

module vcache_checker
  #(parameter int num_tiles_p = 4
    , parameter int data_width_p = 32
  )
  (
    input clk_i
    , input [num_tiles_p-1:0] busy_i
    , input [num_tiles_p-1:0] rd_i
    , input [num_tiles_p-1:0][data_width_p-1:0] exp_i
    , input [num_tiles_p-1:0][15:0] test_i
    , input [num_tiles_p-1:0] n_ack_i
    , input [num_tiles_p-1:0][data_width_p-1:0] n_dat_i
    , input cfg_busy_i
    , input cfg_rd_i
    , input [data_width_p-1:0] cfg_exp_i
    , input [15:0] cfg_test_i
    , input cfg_ack_i
    , input [data_width_p-1:0] cfg_dat_i
    , output int tests_o
    , output int errors_o
  );

  int tests = 0;
  int errors = 0;

  task automatic close_test(input int id, input string name, input logic rd,
                            input logic [data_width_p-1:0] exp,
                            input logic [data_width_p-1:0] got);
    tests = tests + 1;
    if (rd && (got !== exp)) begin
      errors = errors + 1;
      $display("Fail %s in test %0d: expected %h, got %h", name, id, exp, got);
    end
    else begin
      $display("test %0d passed", id);
    end
  endtask

  always @(posedge clk_i) begin
    for (int t = 0; t < num_tiles_p; t++) begin
      if (n_ack_i[t] === 1'b1) begin
        if (busy_i[t]) begin
          close_test(int'(test_i[t]), $sformatf("n_dat_o[%0d]", t), rd_i[t], exp_i[t],
                     n_dat_i[t]);
        end
        else begin
          errors = errors + 1;
          $display("tile %0d acknowledged with no request pending", t);
        end
      end
    end
    if (cfg_ack_i === 1'b1) begin
      if (cfg_busy_i) begin
        close_test(int'(cfg_test_i), "cfg_dat_o", cfg_rd_i, cfg_exp_i, cfg_dat_i);
      end
      else begin
        errors = errors + 1;
        $display("configuration port acknowledged with no request pending");
      end
    end
  end

  assign tests_o = tests;
  assign errors_o = errors;

endmodule

// File: verification/vcache_tb.sv
// ==========================================================================
// vcache tile array testbench
// runs the operations of the pattern file on the north and configuration
// ports; one memory bank per tile answers the south ports
// ==========================================================================

`timescale 1ns/10ps

module vcache_tb;

  localparam int num_tiles_lp = 4;
  localparam int sets_lp = 8;
  localparam int addr_width_lp = 12;
  localparam int data_width_lp = 32;
  localparam int cfg_adr_width_lp = vcache_pkg::cfg_adr_width_c;
  localparam int max_pat_lp = 64;

  logic clk;
  logic reset;

  logic cfg_cyc;
  logic cfg_stb;
  logic cfg_we;
  logic [cfg_adr_width_lp-1:0] cfg_adr;
  logic [data_width_lp-1:0] cfg_dat_w;
  logic [data_width_lp-1:0] cfg_dat_r;
  logic cfg_ack;

  logic [num_tiles_lp-1:0] n_cyc;
  logic [num_tiles_lp-1:0] n_stb;
  logic [num_tiles_lp-1:0] n_we;
  logic [num_tiles_lp-1:0][addr_width_lp-1:0] n_adr;
  logic [num_tiles_lp-1:0][data_width_lp-1:0] n_dat_w;
  logic [num_tiles_lp-1:0][data_width_lp-1:0] n_dat_r;
  logic [num_tiles_lp-1:0] n_ack;

  logic [num_tiles_lp-1:0] s_cyc;
  logic [num_tiles_lp-1:0] s_stb;
  logic [num_tiles_lp-1:0] s_we;
  logic [num_tiles_lp-1:0][addr_width_lp-1:0] s_adr;
  logic [num_tiles_lp-1:0][data_width_lp-1:0] s_dat_w;
  logic [num_tiles_lp-1:0][data_width_lp-1:0] s_dat_r;
  logic [num_tiles_lp-1:0] s_ack;

  // request in flight per port, for the checker
  logic [num_tiles_lp-1:0] busy;
  logic [num_tiles_lp-1:0] rd_flag;
  logic [num_tiles_lp-1:0][data_width_lp-1:0] exp_dat;
  logic [num_tiles_lp-1:0][15:0] test_id;
  logic cfg_busy;
  logic cfg_rd;
  logic [data_width_lp-1:0] cfg_exp;
  logic [15:0] cfg_test;

  // op, tile, address, write data, expected value
  logic [87:0] pat_mem [max_pat_lp];
  logic [data_width_lp-1:0] mem [num_tiles_lp][1 << addr_width_lp];
  int npat = 0;
  int limit = 0;
  int cycles = 0;
  int seed = 59;
  int tests;
  int errors;

  vcache_tile_array #(
    .num_tiles_p(num_tiles_lp)
    ,.sets_p(sets_lp)
    ,.addr_width_p(addr_width_lp)
    ,.data_width_p(data_width_lp)
  ) i_vcache_tile_array (
    .clk_i(clk)
    ,.reset_i(reset)
    ,.cfg_cyc_i(cfg_cyc)
    ,.cfg_stb_i(cfg_stb)
    ,.cfg_we_i(cfg_we)
    ,.cfg_adr_i(cfg_adr)
    ,.cfg_dat_i(cfg_dat_w)
    ,.cfg_dat_o(cfg_dat_r)
    ,.cfg_ack_o(cfg_ack)
    ,.n_cyc_i(n_cyc)
    ,.n_stb_i(n_stb)
    ,.n_we_i(n_we)
    ,.n_adr_i(n_adr)
    ,.n_dat_i(n_dat_w)
    ,.n_dat_o(n_dat_r)
    ,.n_ack_o(n_ack)
    ,.s_cyc_o(s_cyc)
    ,.s_stb_o(s_stb)
    ,.s_we_o(s_we)
    ,.s_adr_o(s_adr)
    ,.s_dat_o(s_dat_w)
    ,.s_dat_i(s_dat_r)
    ,.s_ack_i(s_ack)
  );

  vcache_checker #(
    .num_tiles_p(num_tiles_lp)
    ,.data_width_p(data_width_lp)
  ) i_checker (
    .clk_i(clk)
    ,.busy_i(busy)
    ,.rd_i(rd_flag)
    ,.exp_i(exp_dat)
    ,.test_i(test_id)
    ,.n_ack_i(n_ack)
    ,.n_dat_i(n_dat_r)
    ,.cfg_busy_i(cfg_busy)
    ,.cfg_rd_i(cfg_rd)
    ,.cfg_exp_i(cfg_exp)
    ,.cfg_test_i(cfg_test)
    ,.cfg_ack_i(cfg_ack)
    ,.cfg_dat_i(cfg_dat_r)
    ,.tests_o(tests)
    ,.errors_o(errors)
  );

  bind vcache_tile vcache_assertions #(
    .addr_width_p(addr_width_p)
    ,.data_width_p(data_width_p)
  ) i_assertions (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.state_i(state_r)
    ,.n_cyc_i(n_cyc_i)
    ,.n_stb_i(n_stb_i)
    ,.n_ack_i(n_ack_o)
    ,.s_stb_i(s_stb_o)
    ,.s_we_i(s_we_o)
    ,.s_adr_i(s_adr_o)
    ,.s_wdat_i(s_dat_o)
    ,.s_ack_i(s_ack_i)
  );

  function automatic logic [data_width_lp-1:0] fill_word(input int tile, input int adr);
    return 32'ha000_0000 | (32'(tile) << 16) | 32'(adr);
  endfunction

  // config ops need the whole row idle, tile ops only their own port
  function automatic logic can_issue(input logic [87:0] p);
    if (cfg_busy) begin
      return 1'b0;
    end
    if (p[87:84] >= 4'h2) begin
      return (busy == '0);
    end
    return !busy[int'(p[83:80])];
  endfunction

  task automatic issue(input int idx);
    logic [87:0] p;
    int t;
    p = pat_mem[idx];
    t = int'(p[83:80]);
    if (p[87:84] < 4'h2) begin
      n_cyc[t] = 1'b1;
      n_stb[t] = 1'b1;
      n_we[t] = (p[87:84] == 4'h1);
      n_adr[t] = p[64 +: addr_width_lp];
      n_dat_w[t] = p[63:32];
      rd_flag[t] = (p[87:84] == 4'h0);
      exp_dat[t] = p[31:0];
      test_id[t] = 16'(idx + 1);
      busy[t] = 1'b1;
    end
    else begin
      cfg_cyc = 1'b1;
      cfg_stb = 1'b1;
      cfg_we = (p[87:84] == 4'h2);
      cfg_adr = p[64 +: cfg_adr_width_lp];
      cfg_dat_w = p[63:32];
      cfg_rd = (p[87:84] == 4'h3);
      cfg_exp = p[31:0];
      cfg_test = 16'(idx + 1);
      cfg_busy = 1'b1;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  initial begin : driver
    logic [num_tiles_lp-1:0] acks;
    logic cfg_acked;
    int next;
    reset = 1'b1;
    cfg_cyc = 1'b0;
    cfg_stb = 1'b0;
    cfg_we = 1'b0;
    cfg_adr = '0;
    cfg_dat_w = '0;
    n_cyc = '0;
    n_stb = '0;
    n_we = '0;
    n_adr = '0;
    n_dat_w = '0;
    busy = '0;
    rd_flag = '0;
    exp_dat = '0;
    test_id = '0;
    cfg_busy = 1'b0;
    cfg_rd = 1'b0;
    cfg_exp = '0;
    cfg_test = '0;
    for (int i = 0; i < max_pat_lp; i++) begin
      pat_mem[i] = '1;
    end
    $readmemh("verification/vcache_patterns.hex", pat_mem);
    while ((npat < max_pat_lp) && (pat_mem[npat][87:84] != 4'hf)) begin
      npat++;
    end
    limit = npat * 40 + num_tiles_lp * sets_lp;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    next = 0;
    while ((next < npat) || (busy != '0) || cfg_busy) begin
      @(posedge clk);
      acks = n_ack;
      cfg_acked = cfg_ack;
      #1;
      for (int t = 0; t < num_tiles_lp; t++) begin
        if (acks[t] && busy[t]) begin
          n_cyc[t] = 1'b0;
          n_stb[t] = 1'b0;
          busy[t] = 1'b0;
        end
      end
      if (cfg_acked && cfg_busy) begin
        cfg_cyc = 1'b0;
        cfg_stb = 1'b0;
        cfg_busy = 1'b0;
      end
      // several tiles can start in one cycle
      while ((next < npat) && can_issue(pat_mem[next])) begin
        issue(next);
        next++;
      end
    end
    $display("%0d of %0d tests run, %0d failed", tests, npat, errors);
    if ((errors == 0) && (tests == npat)) begin
      $display("All tests passed");
    end
    else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // one bank per tile, ack 1 to 4 cycles after stb
  initial begin : memory_model
    logic [num_tiles_lp-1:0] stb_seen;
    logic [num_tiles_lp-1:0] we_seen;
    logic [num_tiles_lp-1:0][addr_width_lp-1:0] adr_seen;
    logic [num_tiles_lp-1:0][data_width_lp-1:0] dat_seen;
    int wait_cnt [num_tiles_lp];
    s_ack = '0;
    s_dat_r = '0;
    for (int t = 0; t < num_tiles_lp; t++) begin
      wait_cnt[t] = -1;
      for (int a = 0; a < (1 << addr_width_lp); a++) begin
        mem[t][a] = fill_word(t, a);
      end
    end
    forever begin
      @(posedge clk);
      stb_seen = s_cyc & s_stb;
      we_seen = s_we;
      adr_seen = s_adr;
      dat_seen = s_dat_w;
      #1;
      for (int t = 0; t < num_tiles_lp; t++) begin
        if (s_ack[t]) begin
          s_ack[t] = 1'b0;
          wait_cnt[t] = -1;
        end
        else if (stb_seen[t]) begin
          if (wait_cnt[t] < 0) begin
            wait_cnt[t] = $random(seed) & 3;
          end
          if (wait_cnt[t] == 0) begin
            if (we_seen[t]) begin
              mem[t][adr_seen[t]] = dat_seen[t];
            end
            s_dat_r[t] = mem[t][adr_seen[t]];
            s_ack[t] = 1'b1;
          end
          else begin
            wait_cnt[t] = wait_cnt[t] - 1;
          end
        end
      end
    end
  end

  initial begin : watchdog
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    $display("timeout: requests still pending after %0d cycles", cycles);
    $display("Some tests failed");
    $finish;
  end

endmodule

// File: verification/vcache_patterns.hex
// op_tile_address_wdata_expected, op 0 read, 1 write, 2 config write, 3 config read
// memory starts as a0000000 | tile << 16 | address; op f ends the list
0_0_0005_00000000_a0000005
0_1_0013_00000000_a0010013
0_2_002a_00000000_a002002a
0_3_003f_00000000_a003003f
0_0_0005_00000000_a0000005
3_0_0010_00000000_00000001
3_0_0020_00000000_00000001
0_1_00b3_00000000_a00100b3
0_1_0013_00000000_a0010013
0_1_00b3_00000000_a00100b3
3_0_0021_00000000_00000004
3_0_0011_00000000_00000000
1_2_002a_12345678_00000000
0_2_002a_00000000_12345678
1_2_0100_cafe0100_00000000
0_2_0100_00000000_cafe0100
3_0_0012_00000000_00000001
3_0_0022_00000000_00000002
2_0_0000_00000008_00000000
3_0_0000_00000000_00000008
0_3_003f_00000000_a003003f
0_3_003f_00000000_a003003f
0_0_0005_00000000_a0000005
3_0_0013_00000000_00000000
3_0_0023_00000000_00000001
3_0_0010_00000000_00000002
2_0_0010_00000000_00000000
3_0_0010_00000000_00000000
2_0_0000_00000000_00000000
0_3_003f_00000000_a003003f
3_0_0013_00000000_00000001
3_0_0030_00000000_00000000
f_0_0000_00000000_00000000

// File: filelist.f
hw/vcache_pkg.sv
hw/vcache_store.sv
hw/vcache_tile.sv
hw/vcache_cfg_regs.sv
hw/vcache_tile_array.sv
verification/vcache_assertions.sv
verification/vcache_checker.sv
verification/vcache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= vcache_tb
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/10ps -j 0

FAIL_MSG := Some tests failed
PASS_MSG := All tests passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
